//--- src/uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// Frame format
`define UART_DATA_BITS     10
`define UART_TICKS_PER_BIT 16 // Oversampling ratio

// System clocks between two oversampling ticks
`define UART_CLKS_PER_TICK 4

// Receive buffer entries, must be a power of two
`define RX_FIFO_DEPTH      4

// Register byte offsets
`define REG_RXDATA         0
`define REG_STATUS         4

`endif

//--- src/uart_pkg.sv
`default_nettype none

`include "uart_consts.svh"

package uart_pkg;

    // One received character
    typedef logic [`UART_DATA_BITS-1:0] rx_word_t;

    // FIFO occupancy, counts 0 up to the full depth
    typedef logic [$clog2(`RX_FIFO_DEPTH):0] fifo_level_t;

    typedef logic [3:0]  axil_addr_t; // Register byte address
    typedef logic [31:0] axil_data_t;

    // Receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE  = 2'b00,
        RX_START = 2'b01,
        RX_DATA  = 2'b10,
        RX_STOP  = 2'b11
    } rx_state_t;

endpackage

`default_nettype wire

//--- src/rx_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

// Word stream between receive blocks
interface rx_stream_if import uart_pkg::*; ();

    logic     valid;     // Word and flag are meaningful
    logic     ready;     // Sink takes the word this cycle
    rx_word_t word;
    logic     frame_err; // Stop bit was sampled low

    modport source (
        output valid,
        output word,
        output frame_err,
        input  ready
    );

    modport sink (
        input  valid,
        input  word,
        input  frame_err,
        output ready
    );

endinterface

`default_nettype wire

//--- src/baud_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module baud_tick_gen (
    input  wire  i_clk,
    input  wire  i_reset,
    output logic o_tick // One cycle high per oversampling period
);

    localparam int CNT_W = $clog2(`UART_CLKS_PER_TICK);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`UART_CLKS_PER_TICK - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cnt <= '0;
        end else if (cnt == CNT_MAX) begin
            cnt <= '0; // Wrap
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign o_tick = (cnt == CNT_MAX);

    // Receiver counts ticks, so back-to-back ticks would shorten every bit
    a_tick_single: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_tick |=> !o_tick
    );

endmodule

`default_nettype wire

//--- src/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_rx import uart_pkg::*; (
    input  wire         i_clk,
    input  wire         i_reset,
    input  wire         i_rx,     // Serial line, idles high
    input  wire         i_tick,   // Oversampling tick
    rx_stream_if.source o_stream
);

    localparam int TICK_W = $clog2(`UART_TICKS_PER_BIT);
    localparam int BIT_W  = $clog2(`UART_DATA_BITS);

    localparam logic [TICK_W-1:0] MID_TICK  = TICK_W'(`UART_TICKS_PER_BIT / 2 - 1);
    localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(`UART_TICKS_PER_BIT - 1);
    localparam logic [BIT_W-1:0]  LAST_BIT  = BIT_W'(`UART_DATA_BITS - 1);

    rx_state_t         state, next_state;
    logic [TICK_W-1:0] tick_cnt, next_tick_cnt; // Ticks inside the current bit
    logic [BIT_W-1:0]  bit_cnt, next_bit_cnt;   // Data bits taken so far
    rx_word_t          shift_reg, next_shift_reg;
    logic              done;                    // Stop bit sampled
    logic              valid_q;
    logic              ferr_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            valid_q  <= 1'b0;
        end else begin
            state    <= next_state;
            tick_cnt <= next_tick_cnt;
            bit_cnt  <= next_bit_cnt;
            valid_q  <= done;
        end
    end

    always_ff @(posedge i_clk) begin
        shift_reg <= next_shift_reg;
        if (done) begin
            ferr_q <= ~i_rx; // Low line in the middle of the stop bit
        end
    end

    always_comb begin
        next_state     = state;
        next_tick_cnt  = tick_cnt;
        next_bit_cnt   = bit_cnt;
        next_shift_reg = shift_reg;
        done           = 1'b0;

        case (state)
            RX_IDLE: begin
                if (!i_rx) begin // Falling edge of the start bit
                    next_state    = RX_START;
                    next_tick_cnt = '0;
                end
            end
            RX_START: begin
                if (i_tick) begin
                    if (tick_cnt == MID_TICK) begin
                        next_tick_cnt = '0;
                        next_bit_cnt  = '0;
                        // Line back high means it was only a glitch
                        next_state    = i_rx ? RX_IDLE : RX_DATA;
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end
            RX_DATA: begin
                if (i_tick) begin
                    if (tick_cnt == LAST_TICK) begin
                        next_tick_cnt  = '0;
                        next_shift_reg = {i_rx, shift_reg[`UART_DATA_BITS-1:1]}; // LSB first
                        if (bit_cnt == LAST_BIT) begin
                            next_state = RX_STOP;
                        end else begin
                            next_bit_cnt = bit_cnt + 1'b1;
                        end
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end
            RX_STOP: begin
                if (i_tick) begin
                    if (tick_cnt == LAST_TICK) begin
                        next_state = RX_IDLE;
                        done       = 1'b1;
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end
            default: next_state = RX_IDLE;
        endcase
    end

    // Ready is not looked at, the FIFO flags any drop itself
    assign o_stream.valid     = valid_q;
    assign o_stream.word      = shift_reg;
    assign o_stream.frame_err = ferr_q;

    a_valid_pulse: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_stream.valid |=> !o_stream.valid
    );

endmodule

`default_nettype wire

//--- src/rx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module rx_fifo import uart_pkg::*; (
    input  wire         i_clk,
    input  wire         i_reset,
    rx_stream_if.sink   i_push,     // Words from the receiver
    rx_stream_if.source o_pop,      // Head word towards the register slave
    output fifo_level_t o_level,
    output logic        o_full,
    output logic        o_overflow  // Word dropped this cycle
);

    localparam int AW = $clog2(`RX_FIFO_DEPTH);
    localparam fifo_level_t DEPTH = fifo_level_t'(`RX_FIFO_DEPTH);

    logic [`UART_DATA_BITS:0] mem [`RX_FIFO_DEPTH]; // Framing flag on top of the word
    logic [AW-1:0]            wr_ptr;
    logic [AW-1:0]            rd_ptr;
    fifo_level_t              count;
    logic                     push;
    logic                     pop;

    assign o_full       = (count == DEPTH);
    assign i_push.ready = ~o_full;
    assign push         = i_push.valid & i_push.ready;
    assign o_overflow   = i_push.valid & o_full;

    assign o_pop.valid = (count != '0);
    assign pop         = o_pop.valid & o_pop.ready;
    assign {o_pop.frame_err, o_pop.word} = mem[rd_ptr]; // Head entry
    assign o_level     = count;

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[wr_ptr] <= {i_push.frame_err, i_push.word};
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Idle or both at once
            endcase
        end
    end

    // The slave may only pop a word that is there
    a_no_empty_pop: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_pop.ready |-> o_pop.valid
    );

    a_level_bound: assert property (
        @(posedge i_clk) disable iff (i_reset)
        count <= DEPTH
    );

endmodule

`default_nettype wire

//--- src/axil_rx_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module axil_rx_regs import uart_pkg::*; (
    input  wire              i_clk,
    input  wire              i_reset,
    // Write address
    input  wire              i_awvalid,
    output logic             o_awready,
    input  wire axil_addr_t  i_awaddr,
    // Write data
    input  wire              i_wvalid,
    output logic             o_wready,
    input  wire axil_data_t  i_wdata,
    // Write response
    output logic             o_bvalid,
    input  wire              i_bready,
    output logic [1:0]       o_bresp,
    // Read address
    input  wire              i_arvalid,
    output logic             o_arready,
    input  wire axil_addr_t  i_araddr,
    // Read data
    output logic             o_rvalid,
    input  wire              i_rready,
    output axil_data_t       o_rdata,
    output logic [1:0]       o_rresp,
    // Receive buffer side
    rx_stream_if.sink        i_rx_words,
    input  wire fifo_level_t i_level,
    input  wire              i_full,
    input  wire              i_overflow
);

    localparam axil_addr_t ADDR_RXDATA = axil_addr_t'(`REG_RXDATA);
    localparam axil_addr_t ADDR_STATUS = axil_addr_t'(`REG_STATUS);
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic       rd_hs;
    logic       wr_hs;
    logic       pop;
    logic       ovf_sticky;
    logic       ferr_sticky;
    logic       clr_ovf;
    logic       clr_ferr;
    axil_data_t rd_word;
    logic [1:0] rd_resp;

    // Read side, one outstanding response
    assign o_arready = ~o_rvalid;
    assign rd_hs     = i_arvalid & o_arready;
    assign pop       = rd_hs & (i_araddr == ADDR_RXDATA) & i_rx_words.valid;
    assign i_rx_words.ready = pop;

    always_comb begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        case (i_araddr)
            ADDR_RXDATA: begin
                if (i_rx_words.valid) begin // Empty FIFO reads as zero
                    rd_word     = axil_data_t'(i_rx_words.word);
                    rd_word[31] = i_rx_words.frame_err;
                end
            end
            ADDR_STATUS: begin
                rd_word = axil_data_t'({i_level, ferr_sticky, ovf_sticky,
                                        i_full, i_rx_words.valid});
            end
            default: rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_rvalid <= 1'b0;
        end else if (rd_hs) begin
            o_rvalid <= 1'b1;
        end else if (i_rready) begin
            o_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd_hs) begin
            o_rdata <= rd_word;
            o_rresp <= rd_resp;
        end
    end

    // Write side takes address and data in the same cycle
    assign wr_hs     = i_awvalid & i_wvalid & ~o_bvalid;
    assign o_awready = wr_hs;
    assign o_wready  = wr_hs;
    assign o_bresp   = RESP_OKAY;

    assign clr_ovf  = wr_hs & (i_awaddr == ADDR_STATUS) & i_wdata[2]; // Write one to clear
    assign clr_ferr = wr_hs & (i_awaddr == ADDR_STATUS) & i_wdata[3];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_bvalid    <= 1'b0;
            ovf_sticky  <= 1'b0;
            ferr_sticky <= 1'b0;
        end else begin
            if (wr_hs) begin
                o_bvalid <= 1'b1;
            end else if (i_bready) begin
                o_bvalid <= 1'b0;
            end
            // A new event wins over a clear in the same cycle
            if (i_overflow) begin
                ovf_sticky <= 1'b1;
            end else if (clr_ovf) begin
                ovf_sticky <= 1'b0;
            end
            if (pop && i_rx_words.frame_err) begin
                ferr_sticky <= 1'b1;
            end else if (clr_ferr) begin
                ferr_sticky <= 1'b0;
            end
        end
    end

    a_rdata_hold: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata)
    );

endmodule

`default_nettype wire

//--- src/uart_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_top import uart_pkg::*; (
    input  wire             i_clk,
    input  wire             i_reset,
    input  wire             i_rx,
    // AXI4-Lite slave
    input  wire             i_awvalid,
    output logic            o_awready,
    input  wire axil_addr_t i_awaddr,
    input  wire             i_wvalid,
    output logic            o_wready,
    input  wire axil_data_t i_wdata,
    output logic            o_bvalid,
    input  wire             i_bready,
    output logic [1:0]      o_bresp,
    input  wire             i_arvalid,
    output logic            o_arready,
    input  wire axil_addr_t i_araddr,
    output logic            o_rvalid,
    input  wire             i_rready,
    output axil_data_t      o_rdata,
    output logic [1:0]      o_rresp
);

    logic        tick;
    fifo_level_t level;
    logic        full;
    logic        overflow;

    rx_stream_if rx_link ();   // Receiver into the FIFO
    rx_stream_if fifo_link (); // FIFO head to the register slave

    baud_tick_gen u_tick (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    uart_rx u_rx (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_rx     (i_rx),
        .i_tick   (tick),
        .o_stream (rx_link)
    );

    rx_fifo u_fifo (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_push     (rx_link),
        .o_pop      (fifo_link),
        .o_level    (level),
        .o_full     (full),
        .o_overflow (overflow)
    );

    axil_rx_regs u_regs (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_awvalid  (i_awvalid),
        .o_awready  (o_awready),
        .i_awaddr   (i_awaddr),
        .i_wvalid   (i_wvalid),
        .o_wready   (o_wready),
        .i_wdata    (i_wdata),
        .o_bvalid   (o_bvalid),
        .i_bready   (i_bready),
        .o_bresp    (o_bresp),
        .i_arvalid  (i_arvalid),
        .o_arready  (o_arready),
        .i_araddr   (i_araddr),
        .o_rvalid   (o_rvalid),
        .i_rready   (i_rready),
        .o_rdata    (o_rdata),
        .o_rresp    (o_rresp),
        .i_rx_words (fifo_link),
        .i_level    (level),
        .i_full     (full),
        .i_overflow (overflow)
    );

endmodule

`default_nettype wire

//--- verification/tb_uart_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module tb_uart_rx_top import uart_pkg::*; ();

    localparam int BIT_CLKS   = `UART_TICKS_PER_BIT * `UART_CLKS_PER_TICK; // 64 clocks per bit
    localparam int POLL_LIMIT = 100;
    localparam int NUM_FRAMES = 12;

    localparam axil_addr_t ADDR_DATA   = axil_addr_t'(`REG_RXDATA);
    localparam axil_addr_t ADDR_STATUS = axil_addr_t'(`REG_STATUS);
    localparam axil_addr_t ADDR_BAD    = 4'h8;

    // Columns are word, stop bit level, expected framing flag
    typedef struct packed {
        rx_word_t word;
        logic     stop;
        logic     ferr;
    } frame_t;

    localparam frame_t FRAMES [NUM_FRAMES] = '{
        {10'h155, 1'b1, 1'b0}, // Entries 0 to 4 are read back one at a time
        {10'h2aa, 1'b1, 1'b0},
        {10'h000, 1'b1, 1'b0},
        {10'h3ff, 1'b1, 1'b0},
        {10'h201, 1'b1, 1'b0},
        {10'h0f3, 1'b0, 1'b1}, // Low stop bit
        {10'h123, 1'b1, 1'b0}, // Entries 6 to 10 fill the FIFO and the last is dropped
        {10'h3c4, 1'b1, 1'b0},
        {10'h05a, 1'b1, 1'b0},
        {10'h2e7, 1'b1, 1'b0},
        {10'h181, 1'b1, 1'b0},
        {10'h36d, 1'b1, 1'b0}  // Held read
    };

    logic       i_clk;
    logic       i_reset;
    logic       i_rx;
    logic       i_awvalid;
    logic       o_awready;
    axil_addr_t i_awaddr;
    logic       i_wvalid;
    logic       o_wready;
    axil_data_t i_wdata;
    logic       o_bvalid;
    logic       i_bready;
    logic [1:0] o_bresp;
    logic       i_arvalid;
    logic       o_arready;
    axil_addr_t i_araddr;
    logic       o_rvalid;
    logic       i_rready;
    axil_data_t o_rdata;
    logic [1:0] o_rresp;

    uart_rx_top DUT (.*);

    always #5 i_clk = ~i_clk;

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input axil_data_t expected,
                               input axil_data_t actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic timeout_error(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, POLL_LIMIT);
        stop_run();
    endtask

    // Register image of a popped word
    function automatic axil_data_t expected_data(input frame_t f);
        return {f.ferr, 21'd0, f.word};
    endfunction

    // Called on a falling edge and returns on one
    task automatic drive_line(input logic level, input int cycles);
        i_rx = level;
        repeat (cycles) @(negedge i_clk);
    endtask

    task automatic send_frame(input frame_t f);
        int i;
        int gap;
        gap = 8 + int'($urandom % 64);
        drive_line(1'b0, BIT_CLKS); // Start bit
        for (i = 0; i < `UART_DATA_BITS; i++) begin
            drive_line(f.word[i], BIT_CLKS);
        end
        // Stop level covers the sample point, then the line idles high
        drive_line(f.stop, BIT_CLKS * 3 / 4);
        drive_line(1'b1, BIT_CLKS / 4 + gap);
    endtask

    // Address handshake, then wait for the response
    task automatic read_address(input axil_addr_t addr);
        int n;
        @(negedge i_clk);
        i_arvalid = 1'b1;
        i_araddr  = addr;
        n = 0;
        #1;
        while (!o_arready) begin
            if (n >= POLL_LIMIT) timeout_error("read address handshake");
            n++;
            @(negedge i_clk);
            #1;
        end
        @(negedge i_clk); // Accepted on the rising edge just passed
        i_arvalid = 1'b0;
        n = 0;
        while (!o_rvalid) begin
            if (n >= POLL_LIMIT) timeout_error("read response");
            n++;
            @(negedge i_clk);
        end
    endtask

    task automatic axi_read(input axil_addr_t addr, output axil_data_t data,
                            output logic [1:0] resp);
        read_address(addr);
        data     = o_rdata;
        resp     = o_rresp;
        i_rready = 1'b1;
        @(negedge i_clk);
        i_rready = 1'b0;
    endtask

    task automatic read_held(input axil_addr_t addr, input int hold,
                             input axil_data_t expected, input string name);
        axil_data_t first;
        read_address(addr);
        first = o_rdata;
        check_value(name, expected, first);
        repeat (hold) begin
            @(negedge i_clk);
            check_value({name, " valid"}, 32'h1, axil_data_t'(o_rvalid));
            check_value({name, " stable"}, first, o_rdata);
        end
        i_rready = 1'b1;
        @(negedge i_clk);
        i_rready = 1'b0;
    endtask

    task automatic axi_write(input axil_addr_t addr, input axil_data_t data,
                             output logic [1:0] resp);
        int n;
        @(negedge i_clk);
        i_awvalid = 1'b1;
        i_wvalid  = 1'b1;
        i_awaddr  = addr;
        i_wdata   = data;
        n = 0;
        #1;
        while (!o_awready) begin
            if (n >= POLL_LIMIT) timeout_error("write handshake");
            n++;
            @(negedge i_clk);
            #1;
        end
        // Address and data are taken together
        check_value("write data ready", 32'h1, axil_data_t'(o_wready));
        @(negedge i_clk);
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
        n = 0;
        while (!o_bvalid) begin
            if (n >= POLL_LIMIT) timeout_error("write response");
            n++;
            @(negedge i_clk);
        end
        resp     = o_bresp;
        i_bready = 1'b1;
        @(negedge i_clk);
        i_bready = 1'b0;
    endtask

    // Poll status until one bit is set
    task automatic wait_status_bit(input int bit_idx, input string what);
        axil_data_t st;
        logic [1:0] resp;
        int         n;
        n = 0;
        axi_read(ADDR_STATUS, st, resp);
        while (!st[bit_idx]) begin
            if (n >= POLL_LIMIT) timeout_error(what);
            n++;
            axi_read(ADDR_STATUS, st, resp);
        end
    endtask

    initial begin
        axil_data_t rd;
        logic [1:0] resp;
        int         i;

        i_clk     = 1'b0;
        i_reset   = 1'b1;
        i_rx      = 1'b1; // Idle line
        i_awvalid = 1'b0;
        i_awaddr  = '0;
        i_wvalid  = 1'b0;
        i_wdata   = '0;
        i_bready  = 1'b0;
        i_arvalid = 1'b0;
        i_araddr  = '0;
        i_rready  = 1'b0;
        void'($urandom(32'ha3f759f5));
        repeat (4) @(negedge i_clk);
        i_reset = 1'b0;

        axi_read(ADDR_STATUS, rd, resp);
        check_value("reset status", 32'h0, rd);
        axi_read(ADDR_DATA, rd, resp);
        check_value("empty data read", 32'h0, rd);
        check_value("empty data resp", 32'h0, axil_data_t'(resp));

        for (i = 0; i < 5; i++) begin
            send_frame(FRAMES[i]);
            wait_status_bit(0, "word arrival");
            axi_read(ADDR_DATA, rd, resp);
            check_value("good frame data", expected_data(FRAMES[i]), rd);
            axi_read(ADDR_STATUS, rd, resp);
            check_value("status after pop", 32'h0, rd);
        end

        send_frame(FRAMES[5]);
        wait_status_bit(0, "bad stop word arrival");
        axi_read(ADDR_DATA, rd, resp);
        check_value("framing error data", expected_data(FRAMES[5]), rd);
        axi_read(ADDR_STATUS, rd, resp);
        check_value("framing sticky", 32'h8, rd);
        axi_write(ADDR_STATUS, 32'h8, resp);
        check_value("clear write resp", 32'h0, axil_data_t'(resp));
        axi_read(ADDR_STATUS, rd, resp);
        check_value("framing cleared", 32'h0, rd);

        for (i = 6; i < 11; i++) begin
            send_frame(FRAMES[i]);
        end
        wait_status_bit(2, "overflow flag");
        axi_read(ADDR_STATUS, rd, resp);
        check_value("full status", 32'h47, rd); // Level 4, overflow, full, not empty
        for (i = 6; i < 10; i++) begin
            axi_read(ADDR_DATA, rd, resp);
            check_value("fifo order", expected_data(FRAMES[i]), rd);
        end
        axi_read(ADDR_STATUS, rd, resp);
        check_value("overflow sticky", 32'h4, rd);
        axi_write(ADDR_STATUS, 32'h4, resp);
        axi_read(ADDR_STATUS, rd, resp);
        check_value("overflow cleared", 32'h0, rd);

        axi_read(ADDR_BAD, rd, resp);
        check_value("bad offset resp", 32'h2, axil_data_t'(resp));
        send_frame(FRAMES[11]);
        wait_status_bit(0, "held read word arrival");
        read_held(ADDR_DATA, 6, expected_data(FRAMES[11]), "held read");

        // Low pulse of two ticks is rejected at the middle of the start bit
        drive_line(1'b0, 2 * `UART_CLKS_PER_TICK);
        // Idle longer than a whole frame so a wrongly started one would land
        drive_line(1'b1, (`UART_DATA_BITS + 3) * BIT_CLKS);
        axi_read(ADDR_STATUS, rd, resp);
        check_value("glitch status", 32'h0, rd);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+src
src/uart_pkg.sv
src/rx_stream_if.sv
src/baud_tick_gen.sv
src/uart_rx.sv
src/rx_fifo.sv
src/axil_rx_regs.sv
src/uart_rx_top.sv
verification/tb_uart_rx_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the UART receive testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_uart_rx_top
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -o "V$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

exit 0
